// File: source/exec_config.svh
/*
 * Execution pipeline configuration
 * Data path width, RV32I opcode and funct3 encodings, result credit depth
 */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define XLEN         32

// Major opcodes, instr[6:0]
`define OPC_OP       7'b0110011
`define OPC_OP_IMM   7'b0010011
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011  // Decoded only to flag illegal
`define OPC_STORE    7'b0100011  // Decoded only to flag illegal

// funct3 for register and immediate ALU ops
`define F3_ADD_SUB   3'b000
`define F3_SLL       3'b001
`define F3_SLT       3'b010
`define F3_SLTU      3'b011
`define F3_XOR       3'b100
`define F3_SRL_SRA   3'b101
`define F3_OR        3'b110
`define F3_AND       3'b111

// funct3 for conditional branches
`define F3_BEQ       3'b000
`define F3_BNE       3'b001
`define F3_BLT       3'b100
`define F3_BGE       3'b101
`define F3_BLTU      3'b110
`define F3_BGEU      3'b111

`define CREDIT_COUNT 4           // Result slots in the consumer, 1 to 8
`define CREDIT_W     4

`endif

// File: source/execPkg.sv
/*
 * Shared types of the execution pipeline
 * Instruction word views, decoded operation and the issue and result payloads
 */
`include "exec_config.svh"

package execPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction formats, all 32 bits, MSB first

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rFmt_t;

   typedef struct packed {
      logic [11:0] imm;        // Bit 10 picks SRAI over SRLI
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iFmt_t;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sFmt_t;

   typedef struct packed {
      logic       imm12;       // Sign bit
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
   } bFmt_t;

   typedef struct packed {
      logic [19:0] imm;        // Upper 20 bits of the result
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uFmt_t;

   typedef struct packed {
      logic       imm20;       // Sign bit
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jFmt_t;

   // One word, read through whichever format the opcode calls for
   typedef union packed {
      rFmt_t r;
      iFmt_t i;
      sFmt_t s;
      bFmt_t b;
      uFmt_t u;
      jFmt_t j;
   } instrWord_u;

   ////////////////////////////////////////////////////////////////////////////
   // Decode results

   typedef enum logic [2:0] {
      ALU_REG, ALU_IMM, LUI, AUIPC, JAL, JALR, BRANCH, ILLEGAL
   } opClass_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
      ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
   } aluOp_e;

   ////////////////////////////////////////////////////////////////////////////
   // Stage payloads

   typedef struct packed {
      instrWord_u        instr;
      logic [`XLEN-1:0]  pc;
      logic [`XLEN-1:0]  rs1Val;
      logic [`XLEN-1:0]  rs2Val;
   } issueReq_t;             // 128 bits

   typedef struct packed {
      opClass_e          opClass;
      aluOp_e            aluOp;
      logic [2:0]        funct3;   // Branch condition
      logic [`XLEN-1:0]  imm;      // Sign extended, format specific
      logic [`XLEN-1:0]  pc;
      logic [`XLEN-1:0]  rs1Val;
      logic [`XLEN-1:0]  rs2Val;
   } decodedOp_t;            // 138 bits

   typedef struct packed {
      logic [`XLEN-1:0]  result;
      logic [`XLEN-1:0]  nextPc;
      logic              taken;
      logic              illegal;
   } execResult_t;           // 66 bits

endpackage

// File: source/aluUnit.sv
/*
 * Integer ALU
 * The ten RV32I register and immediate operations, combinational
 */
`timescale 1ns/1ps
`include "exec_config.svh"

module aluUnit (
   input  execPkg::aluOp_e   aluOp,
   input  logic [`XLEN-1:0]  opA,
   input  logic [`XLEN-1:0]  opB,
   output logic [`XLEN-1:0]  aluOut
);
   import execPkg::*;

   logic [4:0] shamt;
   logic       ltSigned;
   logic       ltUnsigned;

   assign shamt      = opB[4:0];                     // RV32 uses 5 bits only
   assign ltSigned   = ($signed(opA) < $signed(opB));
   assign ltUnsigned = (opA < opB);

   ////////////////////////////////////////////////////////////////////////////
   // Operation select

   always_comb begin
      case (aluOp)
         ALU_ADD: begin
            aluOut = opA + opB;
         end
         ALU_SUB: begin
            aluOut = opA - opB;
         end
         ALU_SLL: begin
            aluOut = opA << shamt;
         end
         ALU_SLT: begin
            aluOut = {{(`XLEN-1){1'b0}}, ltSigned};   // 0 or 1
         end
         ALU_SLTU: begin
            aluOut = {{(`XLEN-1){1'b0}}, ltUnsigned};
         end
         ALU_XOR: begin
            aluOut = opA ^ opB;
         end
         ALU_SRL: begin
            aluOut = opA >> shamt;                     // Zero fill
         end
         ALU_SRA: begin
            aluOut = $signed(opA) >>> shamt;           // Sign fill
         end
         ALU_OR: begin
            aluOut = opA | opB;
         end
         ALU_AND: begin
            aluOut = opA & opB;
         end
         default: begin
            aluOut = '0;                               // Unused encodings
         end
      endcase
   end

endmodule

// File: source/instrDecoder.sv
/*
 * Decode stage
 * Classifies the opcode, picks the ALU op and builds the immediate, one cycle
 */
`timescale 1ns/1ps
`include "exec_config.svh"

module instrDecoder (
   input  logic                clk,
   input  logic                rst,
   input  logic                issueValid,
   input  execPkg::issueReq_t  issue,
   output logic                decValid,
   output execPkg::decodedOp_t dec
);
   import execPkg::*;

   instrWord_u       word;
   opClass_e         nextClass;
   aluOp_e           nextAluOp;
   logic             sraSel;
   logic [`XLEN-1:0] immI;
   logic [`XLEN-1:0] immB;
   logic [`XLEN-1:0] immU;
   logic [`XLEN-1:0] immJ;
   logic [`XLEN-1:0] nextImm;

   assign word = issue.instr;

   ////////////////////////////////////////////////////////////////////////////
   // Immediates, one per format

   assign immI = {{20{word.i.imm[11]}}, word.i.imm};
   assign immB = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                  word.b.imm10to5, word.b.imm4to1, 1'b0};  // Halfword aligned
   assign immU = {word.u.imm, 12'b0};
   assign immJ = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19to12,
                  word.j.imm11, word.j.imm10to1, 1'b0};

   ////////////////////////////////////////////////////////////////////////////
   // Opcode class and ALU op

   always_comb begin
      case (word.r.opcode)
         `OPC_OP:     nextClass = ALU_REG;
         `OPC_OP_IMM: nextClass = ALU_IMM;
         `OPC_LUI:    nextClass = LUI;
         `OPC_AUIPC:  nextClass = AUIPC;
         `OPC_JAL:    nextClass = JAL;
         `OPC_JALR:   nextClass = JALR;
         `OPC_BRANCH: nextClass = BRANCH;
         `OPC_LOAD,
         `OPC_STORE:  nextClass = ILLEGAL;     // No memory path here
         default:     nextClass = ILLEGAL;
      endcase
   end

   // funct7[5] in register form, imm[10] in immediate form
   assign sraSel = (nextClass == ALU_REG) ? word.r.funct7[5] : word.i.imm[10];

   always_comb begin
      case (word.r.funct3)
         `F3_ADD_SUB: nextAluOp = (nextClass == ALU_REG && word.r.funct7[5]) ?
                                  ALU_SUB : ALU_ADD;  // No SUBI
         `F3_SLL:     nextAluOp = ALU_SLL;
         `F3_SLT:     nextAluOp = ALU_SLT;
         `F3_SLTU:    nextAluOp = ALU_SLTU;
         `F3_XOR:     nextAluOp = ALU_XOR;
         `F3_SRL_SRA: nextAluOp = sraSel ? ALU_SRA : ALU_SRL;
         `F3_OR:      nextAluOp = ALU_OR;
         default:     nextAluOp = ALU_AND;
      endcase
   end

   always_comb begin
      case (nextClass)
         ALU_IMM, JALR: nextImm = immI;
         LUI, AUIPC:    nextImm = immU;
         JAL:           nextImm = immJ;
         BRANCH:        nextImm = immB;
         default:       nextImm = '0;           // ALU_REG and ILLEGAL
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stage register

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         decValid <= 1'b0;
      end else begin
         decValid <= issueValid;
      end
   end

   always_ff @(posedge clk) begin
      if (issueValid) begin
         dec.opClass <= nextClass;
         dec.aluOp   <= nextAluOp;
         dec.funct3  <= word.b.funct3;
         dec.imm     <= nextImm;
         dec.pc      <= issue.pc;
         dec.rs1Val  <= issue.rs1Val;
         dec.rs2Val  <= issue.rs2Val;
      end
   end

   // Producer must present a fully known request when it issues
   issueKnown: assert property (@(posedge clk) disable iff (rst)
      issueValid |-> !$isunknown(issue))
      else $error("instrDecoder: unknown bits on issue");

endmodule

// File: source/executeStage.sv
/*
 * Execute stage
 * ALU, branch compare, next PC and result select, registered for one cycle
 */
`timescale 1ns/1ps
`include "exec_config.svh"

module executeStage (
   input  logic                clk,
   input  logic                rst,
   input  logic                decValid,
   input  execPkg::decodedOp_t dec,
   output logic                resultValid,
   output execPkg::execResult_t result
);
   import execPkg::*;

   logic [`XLEN-1:0] opB;
   logic [`XLEN-1:0] aluOut;
   logic [`XLEN-1:0] pcPlus4;
   logic [`XLEN-1:0] pcPlusImm;
   logic [`XLEN-1:0] jalrSum;
   logic [`XLEN-1:0] nextPc;
   logic [`XLEN-1:0] nextResult;
   logic             condMet;
   logic             nextTaken;

   assign opB = (dec.opClass == ALU_REG) ? dec.rs2Val : dec.imm;

   aluUnit alu_i (
      .aluOp  (dec.aluOp),
      .opA    (dec.rs1Val),
      .opB    (opB),
      .aluOut (aluOut)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Branch condition and next PC

   always_comb begin
      case (dec.funct3)
         `F3_BEQ:  condMet = (dec.rs1Val == dec.rs2Val);
         `F3_BNE:  condMet = (dec.rs1Val != dec.rs2Val);
         `F3_BLT:  condMet = ($signed(dec.rs1Val) <  $signed(dec.rs2Val));
         `F3_BGE:  condMet = ($signed(dec.rs1Val) >= $signed(dec.rs2Val));
         `F3_BLTU: condMet = (dec.rs1Val <  dec.rs2Val);
         `F3_BGEU: condMet = (dec.rs1Val >= dec.rs2Val);
         default:  condMet = 1'b0;              // Reserved funct3, never taken
      endcase
   end

   assign nextTaken = (dec.opClass == BRANCH) && condMet;
   assign pcPlus4   = dec.pc + `XLEN'(4);
   assign pcPlusImm = dec.pc + dec.imm;        // JAL, branch, AUIPC
   assign jalrSum   = dec.rs1Val + dec.imm;

   always_comb begin
      if (dec.opClass == JALR) begin
         nextPc = {jalrSum[`XLEN-1:1], 1'b0};  // Target LSB cleared
      end else if (dec.opClass == JAL || nextTaken) begin
         nextPc = pcPlusImm;
      end else begin
         nextPc = pcPlus4;
      end
   end

   always_comb begin
      case (dec.opClass)
         ALU_REG, ALU_IMM: nextResult = aluOut;
         LUI:              nextResult = dec.imm;
         AUIPC:            nextResult = pcPlusImm;
         JAL, JALR:        nextResult = pcPlus4;    // Link address
         default:          nextResult = '0;         // BRANCH, ILLEGAL
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output register

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         resultValid <= 1'b0;
      end else begin
         resultValid <= decValid;
      end
   end

   always_ff @(posedge clk) begin
      if (decValid) begin
         result.result  <= nextResult;
         result.nextPc  <= nextPc;
         result.taken   <= nextTaken;
         result.illegal <= (dec.opClass == ILLEGAL);
      end
   end

   // A taken flag at the output traces back to a branch in the decode register
   takenIsBranch: assert property (@(posedge clk) disable iff (rst)
      resultValid && result.taken |-> $past(decValid) && $past(dec.opClass) == BRANCH)
      else $error("executeStage: taken set on a non-branch");

endmodule

// File: source/creditCounter.sv
/*
 * Result credit counter
 * One credit per consumer slot, spent on issue and returned on drain
 */
`timescale 1ns/1ps
`include "exec_config.svh"

module creditCounter (
   input  logic clk,
   input  logic rst,
   input  logic issueFire,
   input  logic creditReturn,
   output logic issueReady
);
   localparam logic [`CREDIT_W-1:0] fullCount = `CREDIT_COUNT;

   logic [`CREDIT_W-1:0] creditCnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         creditCnt <= fullCount;                 // Consumer starts empty
      end else begin
         case ({issueFire, creditReturn})
            2'b10:   creditCnt <= creditCnt - `CREDIT_W'(1);
            2'b01:   creditCnt <= creditCnt + `CREDIT_W'(1);
            default: creditCnt <= creditCnt;      // Both or neither
         endcase
      end
   end

   assign issueReady = (creditCnt != '0);

   // Consumer cannot hand back more than it was given
   noReturnWhenFull: assert property (@(posedge clk) disable iff (rst)
      creditReturn |-> creditCnt != fullCount)
      else $error("creditCounter: credit returned while full");

   noIssueWhenEmpty: assert property (@(posedge clk) disable iff (rst)
      issueFire |-> creditCnt != '0)
      else $error("creditCounter: issue without a credit");

endmodule

// File: source/execCore.sv
/*
 * Execution pipeline top level
 * Decode then execute, two cycles issue to result, credit flow control
 */
`timescale 1ns/1ps

module execCore (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 issueValid,
   input  execPkg::issueReq_t   issue,
   output logic                 issueReady,
   output logic                 resultValid,
   output execPkg::execResult_t result,
   input  logic                 creditReturn
);
   import execPkg::*;

   logic       issueFire;
   logic       decValid;
   decodedOp_t dec;

   assign issueFire = issueValid && issueReady;   // Handshake on the issue side

   ////////////////////////////////////////////////////////////////////////////
   // Pipeline stages

   instrDecoder decoder_i (
      .clk        (clk),
      .rst        (rst),
      .issueValid (issueFire),
      .issue      (issue),
      .decValid   (decValid),
      .dec        (dec)
   );

   executeStage execute_i (
      .clk         (clk),
      .rst         (rst),
      .decValid    (decValid),
      .dec         (dec),
      .resultValid (resultValid),
      .result      (result)
   );

   // Issue gated by free consumer slots
   creditCounter credit_i (
      .clk          (clk),
      .rst          (rst),
      .issueFire    (issueFire),
      .creditReturn (creditReturn),
      .issueReady   (issueReady)
   );

endmodule

// File: tests/clockGen.sv
/*
 * Testbench clock and reset
 * 100 ns clock, reset held high for the first three rising edges
 */
`timescale 1ns/1ps

module clockGen (
   output logic clk,
   output logic rst
);
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;           // 100 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;                       // Released on the third edge
   end

endmodule

// File: tests/execCoreTb.sv
/*
 * Execution pipeline testbench
 * Table of instructions and expected results, credit-returning consumer,
 * scoreboard with latency check and a credit back-pressure phase
 */
`timescale 1ns/1ps
`include "exec_config.svh"

module execCoreTb;
   import execPkg::*;

   logic        clk;
   logic        rst;
   logic        issueValid;
   issueReq_t   issue;
   logic        issueReady;
   logic        resultValid;
   execResult_t result;
   logic        creditReturn = 1'b0;

   issueReq_t   reqTab[$];              // Stimulus table
   execResult_t expTab[$];              // Expected result per row
   execResult_t expQ[$];                // Scoreboard filled on issue fire
   int          fireCycleQ[$];          // Edge index of each fire
   execResult_t driveExp;               // Expected result of the row on the bus
   integer      seed;
   logic        holdCredits;            // Consumer keeps every result
   logic        extraCredit;            // One manual credit pulse
   int          cycleCount  = 0;
   int          fireCount   = 0;
   int          heldResults = 0;

   clockGen clk_i (.clk(clk), .rst(rst));

   execCore dut_i (
      .clk          (clk),
      .rst          (rst),
      .issueValid   (issueValid),
      .issue        (issue),
      .issueReady   (issueReady),
      .resultValid  (resultValid),
      .result       (result),
      .creditReturn (creditReturn)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reporting

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkEqual(input string what, input logic [31:0] got,
                             input logic [31:0] want);
      if (got !== want) begin
         $display("error at %0t: %s is %h, expected %h", $time, what, got, want);
         $display("CHECKS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // RV32I encoders with fixed register numbers

   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'd2, 5'd1, f3, 5'd3, `OPC_OP};
   endfunction

   function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] opc);
      return {imm, 5'd1, f3, 5'd3, opc};
   endfunction

   function automatic logic [31:0] bType(input logic [12:0] off, input logic [2:0] f3);
      return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], `OPC_BRANCH};
   endfunction

   function automatic logic [31:0] uType(input logic [19:0] imm, input logic [6:0] opc);
      return {imm, 5'd3, opc};
   endfunction

   function automatic logic [31:0] jType(input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], 5'd1, `OPC_JAL};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Table building

   task automatic tableRow(input logic [31:0] instr, input logic [31:0] pc,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] res, input logic [31:0] npc,
                           input logic tk, input logic il);
      issueReq_t   req;
      execResult_t exp;
      req.instr   = instr;
      req.pc      = pc;
      req.rs1Val  = rs1;
      req.rs2Val  = rs2;
      exp.result  = res;
      exp.nextPc  = npc;
      exp.taken   = tk;
      exp.illegal = il;
      reqTab.push_back(req);
      expTab.push_back(exp);
   endtask

   task automatic aluRow(input logic [31:0] instr, input logic [31:0] rs1,
                         input logic [31:0] rs2, input logic [31:0] res);
      tableRow(instr, 32'h100, rs1, rs2, res, 32'h104, 1'b0, 1'b0);  // Falls through
   endtask

   task automatic branchRow(input logic [2:0] f3, input logic [12:0] off,
                            input logic [31:0] rs1, input logic [31:0] rs2,
                            input logic [31:0] npc, input logic tk);
      tableRow(bType(off, f3), 32'h500, rs1, rs2, 32'h0, npc, tk, 1'b0);
   endtask

   task automatic buildTable();
      logic [31:0] a;
      logic [31:0] b;
      // Register ALU
      aluRow(rType(7'h00, `F3_ADD_SUB), 32'h5, 32'h7, 32'hC);
      aluRow(rType(7'h20, `F3_ADD_SUB), 32'h5, 32'h7, 32'hFFFF_FFFE);
      aluRow(rType(7'h00, `F3_SLL), 32'h1, 32'h24, 32'h10);            // Upper shamt bits ignored
      aluRow(rType(7'h00, `F3_SLT), 32'hFFFF_FFFF, 32'h1, 32'h1);
      aluRow(rType(7'h00, `F3_SLTU), 32'hFFFF_FFFF, 32'h1, 32'h0);
      aluRow(rType(7'h00, `F3_XOR), 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'hFF00_FF00);
      aluRow(rType(7'h00, `F3_SRL_SRA), 32'h8000_0000, 32'h4, 32'h0800_0000);
      aluRow(rType(7'h20, `F3_SRL_SRA), 32'h8000_0000, 32'h4, 32'hF800_0000);
      aluRow(rType(7'h00, `F3_OR), 32'h0000_F000, 32'h0000_00F0, 32'h0000_F0F0);
      aluRow(rType(7'h00, `F3_AND), 32'h1234_5678, 32'h0000_FFFF, 32'h0000_5678);
      // Immediate ALU with a junk rs2
      aluRow(iType(12'hFFF, `F3_ADD_SUB, `OPC_OP_IMM), 32'hA, 32'hDEAD_BEEF, 32'h9);
      aluRow(iType(12'h003, `F3_SLL, `OPC_OP_IMM), 32'h3, 32'hDEAD_BEEF, 32'h18);
      aluRow(iType(12'hFFE, `F3_SLT, `OPC_OP_IMM), 32'hFFFF_FFFD, 32'hDEAD_BEEF, 32'h1);
      aluRow(iType(12'hFFE, `F3_SLTU, `OPC_OP_IMM), 32'h5, 32'hDEAD_BEEF, 32'h1);
      aluRow(iType(12'h0FF, `F3_XOR, `OPC_OP_IMM), 32'h0F0F, 32'hDEAD_BEEF, 32'h0FF0);
      aluRow(iType(12'h008, `F3_SRL_SRA, `OPC_OP_IMM), 32'hFF00_0000, 32'h0, 32'h00FF_0000);
      aluRow(iType(12'h408, `F3_SRL_SRA, `OPC_OP_IMM), 32'hFF00_0000, 32'h0, 32'hFFFF_0000);
      aluRow(iType(12'h800, `F3_OR, `OPC_OP_IMM), 32'h12, 32'hDEAD_BEEF, 32'hFFFF_F812);
      aluRow(iType(12'h0F0, `F3_AND, `OPC_OP_IMM), 32'h1234_5678, 32'h0, 32'h70);
      // Random ADD operands
      for (int n = 0; n < 8; n++) begin
         a = $random(seed);
         b = $random(seed);
         tableRow(rType(7'h00, `F3_ADD_SUB), 32'h180 + n * 4, a, b, a + b,
                  32'h184 + n * 4, 1'b0, 1'b0);
      end
      // Upper immediates
      tableRow(uType(20'h12345, `OPC_LUI), 32'h200, 32'h0, 32'h0, 32'h1234_5000,
               32'h204, 1'b0, 1'b0);
      tableRow(uType(20'hFFFFF, `OPC_AUIPC), 32'h200, 32'h0, 32'h0, 32'hFFFF_F200,
               32'h204, 1'b0, 1'b0);
      // Jumps link to pc+4
      tableRow(jType(21'h000800), 32'h300, 32'h0, 32'h0, 32'h304, 32'hB00, 1'b0, 1'b0);
      tableRow(jType(21'h1FFFF0), 32'h300, 32'h0, 32'h0, 32'h304, 32'h2F0, 1'b0, 1'b0);
      tableRow(iType(12'h004, 3'b000, `OPC_JALR), 32'h400, 32'h1001, 32'h0, 32'h404,
               32'h1004, 1'b0, 1'b0);                                  // LSB cleared
      tableRow(iType(12'hFFF, 3'b000, `OPC_JALR), 32'h410, 32'h2000, 32'h0, 32'h414,
               32'h1FFE, 1'b0, 1'b0);
      // Branches where -16 against 16 splits signed and unsigned order
      branchRow(`F3_BEQ, 13'h040, 32'hFFFF_FFF0, 32'hFFFF_FFF0, 32'h540, 1'b1);
      branchRow(`F3_BEQ, 13'h040, 32'hFFFF_FFF0, 32'h10, 32'h504, 1'b0);
      branchRow(`F3_BNE, 13'h1FF8, 32'hFFFF_FFF0, 32'h10, 32'h4F8, 1'b1);  // Backward
      branchRow(`F3_BNE, 13'h040, 32'h10, 32'h10, 32'h504, 1'b0);
      branchRow(`F3_BLT, 13'h040, 32'hFFFF_FFF0, 32'h10, 32'h540, 1'b1);
      branchRow(`F3_BLT, 13'h040, 32'h10, 32'hFFFF_FFF0, 32'h504, 1'b0);
      branchRow(`F3_BGE, 13'h040, 32'h10, 32'hFFFF_FFF0, 32'h540, 1'b1);
      branchRow(`F3_BGE, 13'h040, 32'hFFFF_FFF0, 32'h10, 32'h504, 1'b0);
      branchRow(`F3_BLTU, 13'h040, 32'h10, 32'hFFFF_FFF0, 32'h540, 1'b1);
      branchRow(`F3_BLTU, 13'h040, 32'hFFFF_FFF0, 32'h10, 32'h504, 1'b0);
      branchRow(`F3_BGEU, 13'h040, 32'hFFFF_FFF0, 32'h10, 32'h540, 1'b1);
      branchRow(`F3_BGEU, 13'h040, 32'h10, 32'hFFFF_FFF0, 32'h504, 1'b0);
      // Memory ops and unknown opcodes are illegal
      tableRow(iType(12'h004, 3'b010, `OPC_LOAD), 32'h600, 32'h1111_1111, 32'h2222_2222,
               32'h0, 32'h604, 1'b0, 1'b1);
      tableRow({7'h00, 5'd2, 5'd1, 3'b010, 5'd4, `OPC_STORE}, 32'h610, 32'h1111_1111,
               32'h2222_2222, 32'h0, 32'h614, 1'b0, 1'b1);
      tableRow(32'h0000_007F, 32'h620, 32'h1, 32'h2, 32'h0, 32'h624, 1'b0, 1'b1);
      tableRow(32'h0000_0000, 32'h630, 32'h1, 32'h2, 32'h0, 32'h634, 1'b0, 1'b1);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Producer side tasks start right after a rising edge

   task automatic issueEntry(input issueReq_t req, input execResult_t exp);
      int waited;
      waited = 0;
      issueValid <= 1'b1;
      issue      <= req;
      driveExp   <= exp;
      @(negedge clk);
      while (!issueReady) begin                   // Ready sampled mid cycle
         waited++;
         if (waited == 50) abortRun("timeout waiting for issueReady");
         @(negedge clk);
      end
      @(posedge clk);                             // Transfer edge
   endtask

   task automatic waitDrained();
      int waited;
      waited = 0;
      @(negedge clk);
      while (expQ.size() != 0 || creditReturn) begin
         waited++;
         if (waited == 50) abortRun("timeout waiting for outstanding results");
         @(negedge clk);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Issue tracking, scoreboard and consumer

   always @(posedge clk) begin : resultMonitor
      execResult_t want;
      int          firedAt;
      if (issueValid && issueReady) begin
         expQ.push_back(driveExp);
         fireCycleQ.push_back(cycleCount);
         fireCount++;
      end
      if (resultValid) begin
         if (expQ.size() == 0) begin
            abortRun("result appeared with no issue outstanding");
         end else begin
            want    = expQ.pop_front();
            firedAt = fireCycleQ.pop_front();
            checkEqual("result", result.result, want.result);
            checkEqual("nextPc", result.nextPc, want.nextPc);
            checkEqual("taken", 32'(result.taken), 32'(want.taken));
            checkEqual("illegal", 32'(result.illegal), 32'(want.illegal));
            checkEqual("issue to result cycles", 32'(cycleCount - firedAt), 32'd2);
            if (holdCredits) heldResults++;
         end
      end
      creditReturn <= (resultValid && !holdCredits) || extraCredit;  // One pulse per result
      cycleCount++;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin : stimulus
      int waited;
      int firedBefore;
      issueValid  = 1'b0;
      issue       = '0;
      driveExp    = '0;
      holdCredits = 1'b0;
      extraCredit = 1'b0;
      seed        = 32'h17bb_0097;
      buildTable();

      waited = 0;
      @(negedge clk);
      while (rst !== 1'b0) begin
         waited++;
         if (waited == 50) abortRun("timeout waiting for reset release");
         @(negedge clk);
      end
      checkEqual("issueReady after reset", 32'(issueReady), 32'd1);

      // Whole table while the consumer returns credits
      @(posedge clk);
      for (int i = 0; i < reqTab.size(); i++) issueEntry(reqTab[i], expTab[i]);
      issueValid <= 1'b0;
      waitDrained();

      // Back-pressure with no credits coming back
      holdCredits = 1'b1;
      @(posedge clk);
      for (int k = 0; k < `CREDIT_COUNT; k++) issueEntry(reqTab[k], expTab[k]);
      issue    <= reqTab[`CREDIT_COUNT];         // Producer keeps trying
      driveExp <= expTab[`CREDIT_COUNT];
      repeat (10) begin
         @(negedge clk);
         checkEqual("issueReady with credits withheld", 32'(issueReady), 32'd0);
      end
      checkEqual("results while credits withheld", 32'(heldResults), `CREDIT_COUNT);

      // A single credit lets exactly one more through
      firedBefore = fireCount;
      extraCredit = 1'b1;
      @(negedge clk);
      extraCredit = 1'b0;
      waited = 0;
      while (fireCount != firedBefore + 1) begin
         waited++;
         if (waited == 50) abortRun("timeout waiting for the issue after one credit");
         @(negedge clk);
      end
      @(posedge clk);
      issue    <= reqTab[`CREDIT_COUNT + 1];
      driveExp <= expTab[`CREDIT_COUNT + 1];
      repeat (10) begin
         @(negedge clk);
         checkEqual("issues accepted after one credit", 32'(fireCount - firedBefore), 32'd1);
      end
      @(posedge clk);
      issueValid <= 1'b0;
      waitDrained();

      if (expQ.size() == 0 && heldResults == `CREDIT_COUNT + 1) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         abortRun("results missing at end of run");
      end
   end

endmodule

// File: files.f
+incdir+source
source/execPkg.sv
source/aluUnit.sv
source/instrDecoder.sv
source/executeStage.sv
source/creditCounter.sv
source/execCore.sv
tests/clockGen.sv
tests/execCoreTb.sv

// File: run.sh
#!/bin/sh
# Builds the execution pipeline testbench with Verilator and runs it.
# The exit status of the simulation binary is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f files.f \
   --top-module execCoreTb \
   --Mdir obj_dir \
   -o execCoreSim

./obj_dir/execCoreSim
